//--- xy_pkg.sv
package xy_pkg;

  // raw converter code, full 10 bit range
  typedef logic [9:0] adc_t;

  // framebuffer position, room for widths up to 1024
  typedef logic [9:0] coord_t;

  // one color channel on the vga connector
  typedef logic [3:0] color_t;

  typedef struct packed {
    color_t red;
    color_t grn;
    color_t blu;
  } pixel_t;

  // one point as it comes off the adc pins
  typedef struct packed {
    adc_t x;
    adc_t y;
    logic red;
    logic grn;
    logic blu;
  } adc_sample_t;

  // one framebuffer write
  typedef struct packed {
    coord_t x;
    coord_t y;
    pixel_t color;
  } plot_t;

  // write source selection after reset
  typedef enum logic [1:0] {
    clearing,
    settling,
    plotting
  } arb_state_t;

endpackage

//--- adc_xy_capture.sv
`timescale 1ns/1ps

module adc_xy_capture
  import xy_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  // adc pins
  input  logic        adc_strobe,
  input  adc_t        adc_x,
  input  adc_t        adc_y,
  input  logic        adc_red,
  input  logic        adc_grn,
  input  logic        adc_blu,

  // sample stream
  output adc_sample_t sample,
  output logic        valid,
  input  logic        ready
);

  // sample register, loaded on every strobe
  // an untaken sample is simply replaced by the newer one
  always_ff @(posedge clk) begin
    if (adc_strobe) begin
      sample.x   <= adc_x;
      sample.y   <= adc_y;
      sample.red <= adc_red;
      sample.grn <= adc_grn;
      sample.blu <= adc_blu;
    end
  end

  // a strobe in the transfer cycle keeps valid up for the new sample
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (adc_strobe) begin
      valid <= 1'b1;
    end else if (ready) begin
      valid <= 1'b0;
    end
  end

endmodule

//--- xy_scale.sv
`timescale 1ns/1ps

module xy_scale
  import xy_pkg::*;
#(
  parameter int H_VISIBLE = 16,
  parameter int V_VISIBLE = 12,
  parameter int ADC_SHIFT = 6
) (
  input  logic        clk,
  input  logic        reset,

  input  adc_sample_t in_sample,
  input  logic        in_valid,
  output logic        in_ready,

  output plot_t       out_plot,
  output logic        out_valid,
  input  logic        out_ready
);

  coord_t scaled_x;
  coord_t scaled_y;
  logic   on_screen;
  plot_t  next_plot;

  assign scaled_x  = coord_t'(in_sample.x >> ADC_SHIFT);
  assign scaled_y  = coord_t'(in_sample.y >> ADC_SHIFT);
  assign on_screen = (scaled_x < H_VISIBLE) && (scaled_y < V_VISIBLE);

  // each flag drives a whole channel, off or full scale
  assign next_plot.x         = scaled_x;
  assign next_plot.y         = scaled_y;
  assign next_plot.color.red = {$bits(color_t){in_sample.red}};
  assign next_plot.color.grn = {$bits(color_t){in_sample.grn}};
  assign next_plot.color.blu = {$bits(color_t){in_sample.blu}};

  // accept when empty or draining this cycle
  assign in_ready = !out_valid || out_ready;

  // off-screen points are taken but never shown downstream
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid && on_screen;
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready && in_valid) begin
      out_plot <= next_plot;
    end
  end

  // held point must not move while the consumer stalls
  assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_plot));

endmodule

//--- fb_clear.sv
`timescale 1ns/1ps

module fb_clear
  import xy_pkg::*;
#(
  parameter int     H_VISIBLE   = 16,
  parameter int     V_VISIBLE   = 12,
  parameter pixel_t CLEAR_COLOR = '0
) (
  input  logic  clk,
  input  logic  reset,

  output plot_t plot,
  output logic  valid,
  input  logic  ready,
  output logic  last
);

  coord_t x_cnt;
  coord_t y_cnt;
  logic   done;
  logic   at_line_end;
  logic   at_end;

  assign at_line_end = (x_cnt == coord_t'(H_VISIBLE - 1));
  assign at_end      = at_line_end && (y_cnt == coord_t'(V_VISIBLE - 1));

  assign plot.x     = x_cnt;
  assign plot.y     = y_cnt;
  assign plot.color = CLEAR_COLOR;
  assign valid      = !done;
  assign last       = valid && at_end;

  // raster order, x first, one pass per reset
  always_ff @(posedge clk) begin
    if (reset) begin
      x_cnt <= '0;
      y_cnt <= '0;
      done  <= 1'b0;
    end else if (valid && ready) begin
      if (at_end) begin
        done <= 1'b1;
      end else if (at_line_end) begin
        x_cnt <= '0;
        y_cnt <= y_cnt + 1'b1;
      end else begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

endmodule

//--- plot_arbiter.sv
`timescale 1ns/1ps

module plot_arbiter
  import xy_pkg::*;
#(
  parameter int SETTLE_CYCLES = 8
) (
  input  logic  clk,
  input  logic  reset,

  // background sweep
  input  plot_t clr_plot,
  input  logic  clr_valid,
  output logic  clr_ready,
  input  logic  clr_last,

  // scaled adc points
  input  plot_t adc_plot,
  input  logic  adc_valid,
  output logic  adc_ready,

  // to the framebuffer
  output plot_t plot,
  output logic  valid,
  input  logic  ready
);

  localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

  arb_state_t       state;
  logic [CNT_W-1:0] settle_cnt;

  always_comb begin
    plot      = clr_plot;
    valid     = 1'b0;
    clr_ready = 1'b0;
    adc_ready = 1'b0;
    case (state)
      clearing: begin
        valid     = clr_valid;
        clr_ready = ready;
      end
      plotting: begin
        plot      = adc_plot;
        valid     = adc_valid;
        adc_ready = ready;
      end
      default: begin
        // settling, both inputs stalled
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= clearing;
      settle_cnt <= '0;
    end else begin
      case (state)
        clearing: begin
          if (clr_valid && ready && clr_last) begin
            state      <= settling;
            settle_cnt <= '0;
          end
        end
        settling: begin
          if (settle_cnt == CNT_W'(SETTLE_CYCLES - 1)) begin
            state <= plotting;
          end else begin
            settle_cnt <= settle_cnt + 1'b1;
          end
        end
        default: begin
          // plotting until the next reset
        end
      endcase
    end
  end

  // full settle gap with nothing sent after the final clear pixel
  assert property (@(posedge clk) disable iff (reset)
    clr_valid && clr_ready && clr_last |=> !valid [*SETTLE_CYCLES]);

endmodule

//--- vga_timing.sv
`timescale 1ns/1ps

module vga_timing
  import xy_pkg::*;
#(
  parameter int H_VISIBLE     = 16,
  parameter int H_FRONT_PORCH = 2,
  parameter int H_SYNC_PULSE  = 3,
  parameter int H_BACK_PORCH  = 3,
  parameter int V_VISIBLE     = 12,
  parameter int V_FRONT_PORCH = 1,
  parameter int V_SYNC_PULSE  = 2,
  parameter int V_BACK_PORCH  = 1
) (
  input  logic   clk,
  input  logic   reset,

  output coord_t scan_x,
  output coord_t scan_y,
  output logic   visible,
  output logic   hsync,
  output logic   vsync
);

  localparam int H_TOTAL      = H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
  localparam int V_TOTAL      = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;
  localparam int H_SYNC_START = H_VISIBLE + H_FRONT_PORCH;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC_PULSE;
  localparam int V_SYNC_START = V_VISIBLE + V_FRONT_PORCH;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC_PULSE;

  // both totals have to fit the 10 bit counters
  coord_t h_cnt;
  coord_t v_cnt;
  logic   line_end;

  assign line_end = (h_cnt == coord_t'(H_TOTAL - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
      if (v_cnt == coord_t'(V_TOTAL - 1)) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // all outputs one cycle behind the counters, so they line up
  always_ff @(posedge clk) begin
    if (reset) begin
      scan_x  <= '0;
      scan_y  <= '0;
      visible <= 1'b0;
      hsync   <= 1'b1;
      vsync   <= 1'b1;
    end else begin
      scan_x  <= h_cnt;
      scan_y  <= v_cnt;
      visible <= (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);
      // syncs are active low
      hsync   <= !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
      vsync   <= !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));
    end
  end

endmodule

//--- fb_mem.sv
`timescale 1ns/1ps

module fb_mem
  import xy_pkg::*;
#(
  parameter int H_VISIBLE = 16,
  parameter int V_VISIBLE = 12
) (
  input  logic   clk,
  input  logic   reset,

  // write stream
  input  plot_t  plot,
  input  logic   valid,
  output logic   ready,

  // scan side from the timing generator
  input  coord_t scan_x,
  input  coord_t scan_y,
  input  logic   visible,
  input  logic   hsync_in,
  input  logic   vsync_in,

  output color_t vga_red,
  output color_t vga_grn,
  output color_t vga_blu,
  output logic   vga_hsync,
  output logic   vga_vsync
);

  localparam int DEPTH  = H_VISIBLE * V_VISIBLE;
  localparam int ADDR_W = $clog2(DEPTH);

  pixel_t            mem [DEPTH];
  pixel_t            rd_pix;
  coord_t            addr_x;
  coord_t            addr_y;
  logic [ADDR_W-1:0] addr;
  logic              vis_q;

  // video owns the port during active area
  assign ready  = !visible;
  assign addr_x = visible ? scan_x : plot.x;
  assign addr_y = visible ? scan_y : plot.y;
  assign addr   = ADDR_W'(addr_y * H_VISIBLE + addr_x);

  always_ff @(posedge clk) begin
    if (visible) begin
      rd_pix <= mem[addr];
    end else if (valid) begin
      mem[addr] <= plot.color;
    end
  end

  // delay syncs to match the read latency
  always_ff @(posedge clk) begin
    if (reset) begin
      vis_q     <= 1'b0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
    end else begin
      vis_q     <= visible;
      vga_hsync <= hsync_in;
      vga_vsync <= vsync_in;
    end
  end

  // blank outside the active area
  assign vga_red = vis_q ? rd_pix.red : '0;
  assign vga_grn = vis_q ? rd_pix.grn : '0;
  assign vga_blu = vis_q ? rd_pix.blu : '0;

  // upstream clipping must keep every write inside the array
  assert property (@(posedge clk) disable iff (reset)
    valid && ready |-> !visible && plot.x < H_VISIBLE && plot.y < V_VISIBLE);

endmodule

//--- adc_xy_vga.sv
`timescale 1ns/1ps

module adc_xy_vga
  import xy_pkg::*;
#(
  parameter int     H_VISIBLE     = 16,
  parameter int     H_FRONT_PORCH = 2,
  parameter int     H_SYNC_PULSE  = 3,
  parameter int     H_BACK_PORCH  = 3,
  parameter int     V_VISIBLE     = 12,
  parameter int     V_FRONT_PORCH = 1,
  parameter int     V_SYNC_PULSE  = 2,
  parameter int     V_BACK_PORCH  = 1,
  parameter int     ADC_SHIFT     = 6,
  parameter int     SETTLE_CYCLES = 8,
  parameter pixel_t CLEAR_COLOR   = '0
) (
  input  logic   clk,
  input  logic   reset,

  input  logic   adc_strobe,
  input  adc_t   adc_x,
  input  adc_t   adc_y,
  input  logic   adc_red,
  input  logic   adc_grn,
  input  logic   adc_blu,

  output color_t vga_red,
  output color_t vga_grn,
  output color_t vga_blu,
  output logic   vga_hsync,
  output logic   vga_vsync
);

  // capture to scale
  adc_sample_t cap_sample;
  logic        cap_valid;
  logic        cap_ready;

  // scale to arbiter
  plot_t       scl_plot;
  logic        scl_valid;
  logic        scl_ready;

  // clear to arbiter
  plot_t       clr_plot;
  logic        clr_valid;
  logic        clr_ready;
  logic        clr_last;

  // arbiter to framebuffer
  plot_t       fb_plot;
  logic        fb_valid;
  logic        fb_ready;

  // scan side
  coord_t      scan_x;
  coord_t      scan_y;
  logic        visible;
  logic        hsync;
  logic        vsync;

  adc_xy_capture capture_i (
    .clk        (clk),
    .reset      (reset),
    .adc_strobe (adc_strobe),
    .adc_x      (adc_x),
    .adc_y      (adc_y),
    .adc_red    (adc_red),
    .adc_grn    (adc_grn),
    .adc_blu    (adc_blu),
    .sample     (cap_sample),
    .valid      (cap_valid),
    .ready      (cap_ready)
  );

  xy_scale #(
    .H_VISIBLE (H_VISIBLE),
    .V_VISIBLE (V_VISIBLE),
    .ADC_SHIFT (ADC_SHIFT)
  ) scale_i (
    .clk       (clk),
    .reset     (reset),
    .in_sample (cap_sample),
    .in_valid  (cap_valid),
    .in_ready  (cap_ready),
    .out_plot  (scl_plot),
    .out_valid (scl_valid),
    .out_ready (scl_ready)
  );

  fb_clear #(
    .H_VISIBLE   (H_VISIBLE),
    .V_VISIBLE   (V_VISIBLE),
    .CLEAR_COLOR (CLEAR_COLOR)
  ) clear_i (
    .clk   (clk),
    .reset (reset),
    .plot  (clr_plot),
    .valid (clr_valid),
    .ready (clr_ready),
    .last  (clr_last)
  );

  plot_arbiter #(
    .SETTLE_CYCLES (SETTLE_CYCLES)
  ) arbiter_i (
    .clk       (clk),
    .reset     (reset),
    .clr_plot  (clr_plot),
    .clr_valid (clr_valid),
    .clr_ready (clr_ready),
    .clr_last  (clr_last),
    .adc_plot  (scl_plot),
    .adc_valid (scl_valid),
    .adc_ready (scl_ready),
    .plot      (fb_plot),
    .valid     (fb_valid),
    .ready     (fb_ready)
  );

  vga_timing #(
    .H_VISIBLE     (H_VISIBLE),
    .H_FRONT_PORCH (H_FRONT_PORCH),
    .H_SYNC_PULSE  (H_SYNC_PULSE),
    .H_BACK_PORCH  (H_BACK_PORCH),
    .V_VISIBLE     (V_VISIBLE),
    .V_FRONT_PORCH (V_FRONT_PORCH),
    .V_SYNC_PULSE  (V_SYNC_PULSE),
    .V_BACK_PORCH  (V_BACK_PORCH)
  ) timing_i (
    .clk     (clk),
    .reset   (reset),
    .scan_x  (scan_x),
    .scan_y  (scan_y),
    .visible (visible),
    .hsync   (hsync),
    .vsync   (vsync)
  );

  fb_mem #(
    .H_VISIBLE (H_VISIBLE),
    .V_VISIBLE (V_VISIBLE)
  ) mem_i (
    .clk       (clk),
    .reset     (reset),
    .plot      (fb_plot),
    .valid     (fb_valid),
    .ready     (fb_ready),
    .scan_x    (scan_x),
    .scan_y    (scan_y),
    .visible   (visible),
    .hsync_in  (hsync),
    .vsync_in  (vsync),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

endmodule

//--- tb_adc_xy_vga.sv
`timescale 1ns/1ps

module tb_adc_xy_vga
  import xy_pkg::*;
();

  localparam int     H_VISIBLE     = 16;
  localparam int     H_FRONT_PORCH = 2;
  localparam int     H_SYNC_PULSE  = 3;
  localparam int     H_BACK_PORCH  = 3;
  localparam int     V_VISIBLE     = 12;
  localparam int     V_FRONT_PORCH = 1;
  localparam int     V_SYNC_PULSE  = 2;
  localparam int     V_BACK_PORCH  = 1;
  localparam int     ADC_SHIFT     = 6;
  localparam int     SETTLE_CYCLES = 8;
  localparam pixel_t CLEAR_COLOR   = 12'h5a3;

  localparam int H_TOTAL       = H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
  localparam int V_TOTAL       = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;
  localparam int H_SYNC_START  = H_VISIBLE + H_FRONT_PORCH;
  localparam int V_SYNC_START  = V_VISIBLE + V_FRONT_PORCH;
  localparam int FRAME_TIMEOUT = 2 * H_TOTAL * V_TOTAL;
  localparam int LINE_TIMEOUT  = 2 * H_TOTAL;

  logic   clk;
  logic   reset;
  logic   adc_strobe;
  adc_t   adc_x;
  adc_t   adc_y;
  logic   adc_red;
  logic   adc_grn;
  logic   adc_blu;
  color_t vga_red;
  color_t vga_grn;
  color_t vga_blu;
  logic   vga_hsync;
  logic   vga_vsync;

  // expected framebuffer and the last frame seen on the pins
  pixel_t model [V_VISIBLE][H_VISIBLE];
  pixel_t frame [V_VISIBLE][H_VISIBLE];
  integer seed;
  int     error_count;

  adc_xy_vga #(
    .H_VISIBLE     (H_VISIBLE),
    .H_FRONT_PORCH (H_FRONT_PORCH),
    .H_SYNC_PULSE  (H_SYNC_PULSE),
    .H_BACK_PORCH  (H_BACK_PORCH),
    .V_VISIBLE     (V_VISIBLE),
    .V_FRONT_PORCH (V_FRONT_PORCH),
    .V_SYNC_PULSE  (V_SYNC_PULSE),
    .V_BACK_PORCH  (V_BACK_PORCH),
    .ADC_SHIFT     (ADC_SHIFT),
    .SETTLE_CYCLES (SETTLE_CYCLES),
    .CLEAR_COLOR   (CLEAR_COLOR)
  ) dut_i (
    .clk        (clk),
    .reset      (reset),
    .adc_strobe (adc_strobe),
    .adc_x      (adc_x),
    .adc_y      (adc_y),
    .adc_red    (adc_red),
    .adc_grn    (adc_grn),
    .adc_blu    (adc_blu),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_test(input string why);
    error_count++;
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_pixel(input pixel_t got, input pixel_t exp, input string name);
    if (got !== exp) begin
      abort_test($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_sync(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      abort_test($sformatf("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string name);
    if (got != exp) begin
      abort_test($sformatf("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  function automatic pixel_t pins_pixel();
    pixel_t px;
    px.red = vga_red;
    px.grn = vga_grn;
    px.blu = vga_blu;
    return px;
  endfunction

  // one flag per channel, off or full scale
  function automatic pixel_t expand_flags(input logic r, input logic g, input logic b);
    pixel_t px;
    px.red = {4{r}};
    px.grn = {4{g}};
    px.blu = {4{b}};
    return px;
  endfunction

  task automatic wait_vsync_fall();
    int   n;
    logic prev;
    logic found;
    n     = 0;
    found = 1'b0;
    prev  = vga_vsync;
    while (!found) begin
      @(negedge clk);
      found = (prev === 1'b1) && (vga_vsync === 1'b0);
      prev  = vga_vsync;
      n++;
      if (n > FRAME_TIMEOUT) begin
        abort_test("timeout waiting for a falling edge of vga_vsync");
      end
    end
  endtask

  task automatic wait_hsync_rises(input int count);
    int   n;
    int   seen;
    logic prev;
    n    = 0;
    seen = 0;
    prev = vga_hsync;
    while (seen < count) begin
      @(negedge clk);
      if (!prev && vga_hsync) begin
        seen++;
        n = 0;
      end else begin
        n++;
      end
      prev = vga_hsync;
      if (n > LINE_TIMEOUT) begin
        abort_test("timeout waiting for a rising edge of vga_hsync");
      end
    end
  endtask

  // vsync fall marks column 0 of the first line of the sync pulse
  task automatic capture_frame();
    int   line;
    int   col;
    int   hs_low;
    int   vs_lines;
    int   period;
    logic hs_prev;
    logic seen_fall;
    wait_vsync_fall();
    line      = V_SYNC_START;
    col       = 0;
    hs_low    = 0;
    vs_lines  = 0;
    period    = 0;
    hs_prev   = vga_hsync;
    seen_fall = 1'b0;
    repeat (H_TOTAL * V_TOTAL) begin
      check_sync(vga_hsync, !(col >= H_SYNC_START && col < H_SYNC_START + H_SYNC_PULSE),
                 "vga_hsync");
      check_sync(vga_vsync, !(line >= V_SYNC_START && line < V_SYNC_START + V_SYNC_PULSE),
                 "vga_vsync");
      if (line < V_VISIBLE && col < H_VISIBLE) begin
        frame[line][col] = pins_pixel();
      end else begin
        check_pixel(pins_pixel(), '0, "blanked color");
      end
      // distance between hsync falls
      if (hs_prev && !vga_hsync) begin
        if (seen_fall) begin
          check_count(period, H_TOTAL, "hsync period");
        end
        seen_fall = 1'b1;
        period    = 0;
      end
      period++;
      hs_prev = vga_hsync;
      if (!vga_hsync) begin
        hs_low++;
      end
      if (col == 0 && !vga_vsync) begin
        vs_lines++;
      end
      if (col == H_TOTAL - 1) begin
        check_count(hs_low, H_SYNC_PULSE, "hsync low clocks");
        hs_low = 0;
        col    = 0;
        line   = (line == V_TOTAL - 1) ? 0 : line + 1;
      end else begin
        col++;
      end
      @(negedge clk);
    end
    check_count(vs_lines, V_SYNC_PULSE, "vsync low lines");
  endtask

  task automatic compare_frame(input string what);
    for (int y = 0; y < V_VISIBLE; y++) begin
      for (int x = 0; x < H_VISIBLE; x++) begin
        check_pixel(frame[y][x], model[y][x], $sformatf("%s pixel (%0d,%0d)", what, x, y));
      end
    end
  endtask

  // one strobe cycle, returns on the next falling edge
  task automatic strobe_sample(input adc_t x, input adc_t y,
                               input logic r, input logic g, input logic b);
    adc_x      = x;
    adc_y      = y;
    adc_red    = r;
    adc_grn    = g;
    adc_blu    = b;
    adc_strobe = 1'b1;
    @(negedge clk);
    adc_strobe = 1'b0;
  endtask

  task automatic apply_point(input adc_t x, input adc_t y,
                             input logic r, input logic g, input logic b);
    int sx;
    int sy;
    sx = int'(x) >> ADC_SHIFT;
    sy = int'(y) >> ADC_SHIFT;
    if (sx < H_VISIBLE && sy < V_VISIBLE) begin
      model[sy][sx] = expand_flags(r, g, b);
    end
  endtask

  task automatic plot_point(input adc_t x, input adc_t y,
                            input logic r, input logic g, input logic b);
    strobe_sample(x, y, r, g, b);
    apply_point(x, y, r, g, b);
    repeat (2 * H_TOTAL) @(negedge clk);
  endtask

  task automatic check_idle_outputs();
    check_sync(vga_hsync, 1'b1, "vga_hsync");
    check_sync(vga_vsync, 1'b1, "vga_vsync");
    check_pixel(pins_pixel(), '0, "color after reset");
  endtask

  task automatic test_reset();
    repeat (2) begin
      @(negedge clk);
      check_idle_outputs();
    end
    reset = 1'b0;
    @(negedge clk);
    check_idle_outputs();
  endtask

  task automatic test_sync();
    capture_frame();
    $display("sync geometry checked over one frame");
  endtask

  task automatic test_clear();
    for (int y = 0; y < V_VISIBLE; y++) begin
      for (int x = 0; x < H_VISIBLE; x++) begin
        model[y][x] = CLEAR_COLOR;
      end
    end
    capture_frame();
    compare_frame("clear");
    $display("arbiter state after clear: %s", dut_i.arbiter_i.state.name());
  endtask

  task automatic test_plot();
    int rnd_a;
    int rnd_b;
    repeat (6) begin
      rnd_a = $random(seed);
      rnd_b = $random(seed);
      plot_point(adc_t'(rnd_a[9:0]), adc_t'(rnd_b[15:0] % (V_VISIBLE << ADC_SHIFT)),
                 rnd_a[16], rnd_a[17], rnd_a[18]);
    end
    // same cell twice, second one wins
    plot_point(10'h0c5, 10'h145, 1'b1, 1'b0, 1'b0);
    plot_point(10'h0f0, 10'h17f, 1'b0, 1'b1, 1'b1);
    capture_frame();
    compare_frame("plot");
  endtask

  task automatic test_clip();
    int rnd_a;
    plot_point(10'h000, adc_t'(V_VISIBLE << ADC_SHIFT), 1'b1, 1'b1, 1'b1);
    repeat (3) begin
      rnd_a = $random(seed);
      plot_point(adc_t'(rnd_a[9:0]), adc_t'((V_VISIBLE << ADC_SHIFT) + rnd_a[23:16]),
                 1'b1, 1'b0, 1'b1);
    end
    capture_frame();
    compare_frame("clip");
  endtask

  // burst inside the visible part of line 4
  task automatic test_newest();
    wait_vsync_fall();
    wait_hsync_rises(V_SYNC_PULSE + V_BACK_PORCH + 4);
    repeat (2) @(negedge clk);
    // this one parks in the scale register
    strobe_sample(10'h040, 10'h040, 1'b1, 1'b1, 1'b0);
    @(negedge clk);
    strobe_sample(10'h080, 10'h080, 1'b0, 1'b0, 1'b1);
    strobe_sample(10'h0c0, 10'h0c0, 1'b1, 1'b0, 1'b1);
    strobe_sample(10'h100, 10'h100, 1'b0, 1'b1, 1'b0);
    apply_point(10'h040, 10'h040, 1'b1, 1'b1, 1'b0);
    apply_point(10'h100, 10'h100, 1'b0, 1'b1, 1'b0);
    repeat (2 * H_TOTAL) @(negedge clk);
    capture_frame();
    compare_frame("newest sample");
  endtask

  initial begin
    seed        = 41134;
    error_count = 0;
    reset       = 1'b1;
    adc_strobe  = 1'b0;
    adc_x       = '0;
    adc_y       = '0;
    adc_red     = 1'b0;
    adc_grn     = 1'b0;
    adc_blu     = 1'b0;
    test_reset();
    test_sync();
    test_clear();
    test_plot();
    test_clip();
    test_newest();
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
xy_pkg.sv
adc_xy_capture.sv
xy_scale.sv
fb_clear.sv
plot_arbiter.sv
vga_timing.sv
fb_mem.sv
adc_xy_vga.sv
tb_adc_xy_vga.sv

//--- Bender.yml
package:
  name: adc_xy_vga

sources:
  - files:
      - xy_pkg.sv
      - adc_xy_capture.sv
      - xy_scale.sv
      - fb_clear.sv
      - plot_arbiter.sv
      - vga_timing.sv
      - fb_mem.sv
      - adc_xy_vga.sv
  - target: test
    files:
      - tb_adc_xy_vga.sv
